//--- hdl/tile_pkg.sv
// Shared widths, flit format and address map of the compute tile.
// Word-aligned single transfers only. Byte lanes follow sel.
// FIFO_DEPTH must stay a power of two for the queue pointers to wrap.
`default_nettype none

package tile_pkg;

   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 32;
   localparam int SEL_W      = DATA_W / 8;

   localparam int RAM_WORDS  = 256;                      // 1 KiB local memory
   localparam int RAM_AW     = $clog2(RAM_WORDS);

   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);    // Holds 0..FIFO_DEPTH

   localparam logic [3:0] NA_REGION = 4'hE;              // Top address nibble

   // Byte offsets of the adapter registers inside the region
   localparam logic [3:0] NA_TX_DATA = 4'h0;
   localparam logic [3:0] NA_TX_LAST = 4'h4;
   localparam logic [3:0] NA_STATUS  = 4'h8;
   localparam logic [3:0] NA_RX_DATA = 4'hC;

   // Status word layout
   localparam int ST_TX_FREE_LSB = 0;
   localparam int ST_RX_CNT_LSB  = 8;
   localparam int ST_RX_LAST     = 16;

   typedef struct packed {
      logic              last;                           // Closes a message
      logic [DATA_W-1:0] data;
   } flit_t;

   typedef enum logic [1:0] {
      REGION_RAM,
      REGION_NA,
      REGION_NONE
   } region_e;

endpackage

`default_nettype wire

//--- hdl/flit_fifo.sv
// Flit queue with combinational head output.
// Push when full and pop when empty are dropped. Callers avoid both.
`default_nettype none

module flit_fifo (
   input  logic                              clk,
   input  logic                              arst_n_i,
   input  logic                              push_i,
   input  tile_pkg::flit_t                   flit_i,
   output logic                              full_o,
   input  logic                              pop_i,
   output tile_pkg::flit_t                   flit_o,
   output logic                              empty_o,
   output logic [tile_pkg::FIFO_CNT_W-1:0]   count_o
);

   import tile_pkg::*;

   flit_t                 mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr_q;
   logic [FIFO_PTR_W-1:0] rd_ptr_q;
   logic [FIFO_CNT_W-1:0] cnt_q;
   logic                  do_push;
   logic                  do_pop;

   assign full_o  = (cnt_q == FIFO_CNT_W'(FIFO_DEPTH));
   assign empty_o = (cnt_q == '0);
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;
   assign flit_o  = mem[rd_ptr_q];                       // Head visible without a pop
   assign count_o = cnt_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;                 // Wraps at depth
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;                     // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= flit_i;
      end
   end

endmodule

`default_nettype wire

//--- hdl/tile_ram.sv
// Local single-port RAM slave.
// Expects a one-cycle strobe per transfer and answers one cycle later.
// Contents start undefined after power-up and are not cleared by reset.
`default_nettype none

module tile_ram (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [tile_pkg::RAM_AW-1:0]   word_adr_i,
   input  logic [tile_pkg::DATA_W-1:0]   dat_i,
   input  logic [tile_pkg::SEL_W-1:0]    sel_i,
   output logic                          ack_o,
   output logic [tile_pkg::DATA_W-1:0]   dat_o
);

   import tile_pkg::*;

   logic [DATA_W-1:0] mem [RAM_WORDS];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= stb_i;                                 // One pulse per strobe
      end
   end

   always_ff @(posedge clk) begin
      if (stb_i) begin
         dat_o <= mem[word_adr_i];                       // Old word on a write
         if (we_i) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (sel_i[b]) begin
                  mem[word_adr_i][8*b +: 8] <= dat_i[8*b +: 8];
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/noc_adapter.sv
// Message-passing network adapter with one transmit and one receive queue.
// Single virtual channel. Bus strobe must be one cycle per transfer.
// Writes to a full queue, reads of an empty one and wrong-direction
// accesses are answered with err and leave the queues untouched.
`default_nettype none

module noc_adapter (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [1:0]                    reg_off_i,
   input  logic [tile_pkg::DATA_W-1:0]   dat_i,
   output logic                          ack_o,
   output logic                          err_o,
   output logic [tile_pkg::DATA_W-1:0]   dat_o,
   output tile_pkg::flit_t               noc_out_flit_o,
   output logic                          noc_out_valid_o,
   input  logic                          noc_out_ready_i,
   input  tile_pkg::flit_t               noc_in_flit_i,
   input  logic                          noc_in_valid_i,
   output logic                          noc_in_ready_o,
   output logic                          irq_o
);

   import tile_pkg::*;

   flit_t                 tx_in;
   flit_t                 tx_flit;
   flit_t                 rx_flit;
   logic                  tx_full;
   logic                  tx_empty;
   logic                  tx_push;
   logic                  tx_pop;
   logic                  rx_full;
   logic                  rx_empty;
   logic                  rx_push;
   logic                  rx_pop;
   logic [FIFO_CNT_W-1:0] tx_cnt;
   logic [FIFO_CNT_W-1:0] rx_cnt;
   logic [FIFO_CNT_W-1:0] tx_free;
   logic [3:0]            off;
   logic                  is_tx;
   logic                  is_status;
   logic                  is_rx;
   logic                  req_err;
   logic [DATA_W-1:0]     status;
   logic [DATA_W-1:0]     rd_dat;

   assign off       = {reg_off_i, 2'b00};                // Word index to byte offset
   assign is_tx     = (off == NA_TX_DATA) | (off == NA_TX_LAST);
   assign is_status = (off == NA_STATUS);
   assign is_rx     = (off == NA_RX_DATA);

   // Error unless the access matches a legal direction with queue room
   always_comb begin
      req_err = 1'b1;
      if (we_i) begin
         if (is_tx) begin
            req_err = tx_full;
         end
      end else begin
         if (is_status) begin
            req_err = 1'b0;
         end else if (is_rx) begin
            req_err = rx_empty;
         end
      end
   end

   assign tx_in.last = (off == NA_TX_LAST);
   assign tx_in.data = dat_i;
   assign tx_push    = stb_i & we_i & is_tx & ~tx_full;
   assign rx_pop     = stb_i & ~we_i & is_rx & ~rx_empty;

   assign tx_free = FIFO_CNT_W'(FIFO_DEPTH) - tx_cnt;

   always_comb begin
      status = '0;
      status[ST_TX_FREE_LSB +: FIFO_CNT_W] = tx_free;
      status[ST_RX_CNT_LSB +: FIFO_CNT_W]  = rx_cnt;
      status[ST_RX_LAST]                   = rx_flit.last & ~rx_empty;
   end

   assign rd_dat = is_status ? status : rx_flit.data;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
      end else begin
         ack_o <= stb_i & ~req_err;
         err_o <= stb_i & req_err;
      end
   end

   always_ff @(posedge clk) begin
      if (stb_i && !we_i) begin
         dat_o <= rd_dat;                                // Head captured before pop
      end
   end

   // NoC side handshakes
   assign noc_out_flit_o  = tx_flit;
   assign noc_out_valid_o = ~tx_empty;
   assign tx_pop          = noc_out_valid_o & noc_out_ready_i;
   assign noc_in_ready_o  = ~rx_full;
   assign rx_push         = noc_in_valid_i & ~rx_full;
   assign irq_o           = ~rx_empty;                   // Level while data waits

   flit_fifo u_tx (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .push_i   (tx_push),
      .flit_i   (tx_in),
      .full_o   (tx_full),
      .pop_i    (tx_pop),
      .flit_o   (tx_flit),
      .empty_o  (tx_empty),
      .count_o  (tx_cnt)
   );

   flit_fifo u_rx (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .push_i   (rx_push),
      .flit_i   (noc_in_flit_i),
      .full_o   (rx_full),
      .pop_i    (rx_pop),
      .flit_o   (rx_flit),
      .empty_o  (rx_empty),
      .count_o  (rx_cnt)
   );

endmodule

`default_nettype wire

//--- hdl/bus_decoder.sv
// Address decoder for one master and two slaves.
// Address must stay stable while stb is high. One transfer in flight.
// Unmapped addresses, including the old boot ROM nibble, get err.
`default_nettype none

module bus_decoder (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  logic                          cyc_i,
   input  logic                          stb_i,
   input  logic [tile_pkg::ADDR_W-1:0]   adr_i,
   output logic                          ack_o,
   output logic                          err_o,
   output logic [tile_pkg::DATA_W-1:0]   dat_o,
   output logic                          ram_stb_o,
   output logic                          na_stb_o,
   input  logic                          ram_ack_i,
   input  logic [tile_pkg::DATA_W-1:0]   ram_dat_i,
   input  logic                          na_ack_i,
   input  logic                          na_err_i,
   input  logic [tile_pkg::DATA_W-1:0]   na_dat_i
);

   import tile_pkg::*;

   region_e region;
   logic    req;
   logic    pend_q;
   logic    none_err_q;
   logic    resp_any;

   always_comb begin
      if (adr_i[ADDR_W-1 -: 4] == NA_REGION) begin
         region = REGION_NA;
      end else if (adr_i[ADDR_W-1:RAM_AW+2] == '0) begin
         region = REGION_RAM;                            // Below RAM_WORDS*4
      end else begin
         region = REGION_NONE;
      end
   end

   assign req       = cyc_i & stb_i & ~pend_q;           // First cycle of a held strobe
   assign ram_stb_o = req & (region == REGION_RAM);
   assign na_stb_o  = req & (region == REGION_NA);
   assign resp_any  = ram_ack_i | na_ack_i | na_err_i | none_err_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pend_q     <= 1'b0;
         none_err_q <= 1'b0;
      end else begin
         none_err_q <= req & (region == REGION_NONE);
         if (resp_any) begin
            pend_q <= 1'b0;
         end else if (req) begin
            pend_q <= 1'b1;
         end
      end
   end

   always_comb begin
      ack_o = 1'b0;
      err_o = 1'b0;
      dat_o = ram_dat_i;
      case (region)
         REGION_RAM: ack_o = ram_ack_i;
         REGION_NA: begin
            ack_o = na_ack_i;
            err_o = na_err_i;
            dat_o = na_dat_i;
         end
         default: err_o = none_err_q;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/compute_tile.sv
// Compute tile top with local RAM and network adapter on one bus.
// Single master, single transfers, one reset and one NoC channel.
`default_nettype none

module compute_tile (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  logic                          cyc_i,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [tile_pkg::ADDR_W-1:0]   adr_i,
   input  logic [tile_pkg::DATA_W-1:0]   dat_i,
   input  logic [tile_pkg::SEL_W-1:0]    sel_i,
   output logic                          ack_o,
   output logic                          err_o,
   output logic [tile_pkg::DATA_W-1:0]   dat_o,
   output tile_pkg::flit_t               noc_out_flit_o,
   output logic                          noc_out_valid_o,
   input  logic                          noc_out_ready_i,
   input  tile_pkg::flit_t               noc_in_flit_i,
   input  logic                          noc_in_valid_i,
   output logic                          noc_in_ready_o,
   output logic                          irq_o
);

   import tile_pkg::*;

   logic              ram_stb;
   logic              ram_ack;
   logic [DATA_W-1:0] ram_dat;
   logic              na_stb;
   logic              na_ack;
   logic              na_err;
   logic [DATA_W-1:0] na_dat;

   bus_decoder u_bus (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .adr_i     (adr_i),
      .ack_o     (ack_o),
      .err_o     (err_o),
      .dat_o     (dat_o),
      .ram_stb_o (ram_stb),
      .na_stb_o  (na_stb),
      .ram_ack_i (ram_ack),
      .ram_dat_i (ram_dat),
      .na_ack_i  (na_ack),
      .na_err_i  (na_err),
      .na_dat_i  (na_dat)
   );

   tile_ram u_ram (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .stb_i      (ram_stb),
      .we_i       (we_i),
      .word_adr_i (adr_i[RAM_AW+1:2]),                   // Word index
      .dat_i      (dat_i),
      .sel_i      (sel_i),
      .ack_o      (ram_ack),
      .dat_o      (ram_dat)
   );

   noc_adapter u_na (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .stb_i           (na_stb),
      .we_i            (we_i),
      .reg_off_i       (adr_i[3:2]),                     // Register select
      .dat_i           (dat_i),
      .ack_o           (na_ack),
      .err_o           (na_err),
      .dat_o           (na_dat),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .irq_o           (irq_o)
   );

endmodule

`default_nettype wire

//--- test/compute_tile_sva.sv
// Bus and NoC output protocol assertions, bound into compute_tile.
// Assumes single transfers with one response per strobe.
`default_nettype none

module compute_tile_sva (
   input logic            clk,
   input logic            arst_n_i,
   input logic            cyc_i,
   input logic            stb_i,
   input logic            ack_i,
   input logic            err_i,
   input tile_pkg::flit_t noc_out_flit_i,
   input logic            noc_out_valid_i,
   input logic            noc_out_ready_i
);
   timeunit 1ns;
   timeprecision 1ps;

   a_one_resp : assert property (@(posedge clk) disable iff (!arst_n_i)
      !(ack_i && err_i))
      else $error("ack_o and err_o high in the same cycle");

   a_resp_after_stb : assert property (@(posedge clk) disable iff (!arst_n_i)
      (ack_i || err_i) |-> $past(cyc_i && stb_i))
      else $error("Bus response without a strobe in the cycle before");

   // Stalled flit holds until the NoC takes it
   a_out_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
      (noc_out_valid_i && !noc_out_ready_i) |=> (noc_out_valid_i && $stable(noc_out_flit_i)))
      else $error("noc_out_flit_o changed while stalled");

endmodule

bind compute_tile compute_tile_sva u_sva (
   .clk             (clk),
   .arst_n_i        (arst_n_i),
   .cyc_i           (cyc_i),
   .stb_i           (stb_i),
   .ack_i           (ack_o),
   .err_i           (err_o),
   .noc_out_flit_i  (noc_out_flit_o),
   .noc_out_valid_i (noc_out_valid_o),
   .noc_out_ready_i (noc_out_ready_i)
);

`default_nettype wire

//--- test/tb_compute_tile.sv
// Table-driven testbench for the compute tile bus and NoC ports.
// Expects every bus response exactly one cycle after the strobe is sampled.
`default_nettype none

module tb_compute_tile;
   timeunit 1ns;
   timeprecision 1ps;

   import tile_pkg::*;

   localparam int WAIT_LIMIT = 40;                       // Cycles before a wait gives up

   typedef struct packed {
      logic              wr;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] wdat;
      logic [SEL_W-1:0]  sel;
      logic [DATA_W-1:0] exp_dat;                        // Checked on acked reads only
      logic              exp_err;
   } entry_t;

   logic              clk = 1'b0;
   logic              arst_n_i;
   logic              cyc_i;
   logic              stb_i;
   logic              we_i;
   logic [ADDR_W-1:0] adr_i;
   logic [DATA_W-1:0] dat_i;
   logic [SEL_W-1:0]  sel_i;
   logic              ack_o;
   logic              err_o;
   logic [DATA_W-1:0] dat_o;
   flit_t             noc_out_flit_o;
   logic              noc_out_valid_o;
   logic              noc_out_ready_i;
   flit_t             noc_in_flit_i;
   logic              noc_in_valid_i;
   logic              noc_in_ready_o;
   logic              irq_o;

   entry_t      tbl[$];
   flit_t       send_q[$];                               // Flits to offer on NoC in
   flit_t       out_q[$];                                // Flits seen on NoC out
   int          in_acc = 0;
   int          errors = 0;
   int          xfers  = 0;
   logic [31:0] rng    = 32'd83645;

   compute_tile DUT (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .cyc_i           (cyc_i),
      .stb_i           (stb_i),
      .we_i            (we_i),
      .adr_i           (adr_i),
      .dat_i           (dat_i),
      .sel_i           (sel_i),
      .ack_o           (ack_o),
      .err_o           (err_o),
      .dat_o           (dat_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .irq_o           (irq_o)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      if (arst_n_i && noc_out_valid_o && noc_out_ready_i) begin
         out_q.push_back(noc_out_flit_o);                // Transfer at this edge
      end
   end

   always @(posedge clk) begin
      if (arst_n_i && noc_in_valid_i && noc_in_ready_o) begin
         in_acc <= in_acc + 1;
      end
   end

   // NoC input driver offering send_q in order and holding each flit until taken
   initial begin
      noc_in_valid_i = 1'b0;
      noc_in_flit_i  = '0;
      forever begin
         @(negedge clk);
         if (in_acc < send_q.size()) begin
            noc_in_valid_i = 1'b1;
            noc_in_flit_i  = send_q[in_acc];
         end else begin
            noc_in_valid_i = 1'b0;
         end
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Byte lanes with sel set take the new byte
   function automatic logic [31:0] ram_merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                             input logic [3:0] sel);
      logic [31:0] res;
      for (int b = 0; b < 4; b++) begin
         res[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
      end
      return res;
   endfunction

   function automatic entry_t make_entry(input logic wr, input logic [31:0] adr,
                                         input logic [31:0] wdat, input logic [3:0] sel,
                                         input logic [31:0] exp_dat, input logic exp_err);
      entry_t e;
      e.wr      = wr;
      e.adr     = adr;
      e.wdat    = wdat;
      e.sel     = sel;
      e.exp_dat = exp_dat;
      e.exp_err = exp_err;
      return e;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
   endtask

   task automatic bus_xfer(input logic wr, input logic [31:0] adr, input logic [31:0] wdat,
                           input logic [3:0] sel, output logic [31:0] rdat,
                           output logic got_ack, output logic got_err);
      int n;
      n = 0;
      @(negedge clk);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = wr;
      adr_i = adr;
      dat_i = wdat;
      sel_i = sel;
      do begin
         @(negedge clk);
         n++;
      end while (ack_o !== 1'b1 && err_o !== 1'b1 && n < WAIT_LIMIT);
      rdat    = dat_o;
      got_ack = ack_o;
      got_err = err_o;
      if (got_ack !== 1'b1 && got_err !== 1'b1) begin
         errors++;
         $display("No bus response for address %h within %0d cycles", adr, WAIT_LIMIT);
      end else if (n != 1) begin
         errors++;
         $display("Bus response for address %h came after %0d cycles, not 1", adr, n);
      end
      cyc_i = 1'b0;                                      // Drop in the response cycle
      stb_i = 1'b0;
      we_i  = 1'b0;
      xfers++;
   endtask

   task automatic run_entry(input entry_t e);
      logic [31:0] rdat;
      logic        got_ack;
      logic        got_err;
      bus_xfer(e.wr, e.adr, e.wdat, e.sel, rdat, got_ack, got_err);
      if (got_err !== e.exp_err) report_mismatch("err_o", 32'(got_err), 32'(e.exp_err));
      if (got_ack !== !e.exp_err) report_mismatch("ack_o", 32'(got_ack), 32'(!e.exp_err));
      if (!e.wr && !e.exp_err && rdat !== e.exp_dat) report_mismatch("dat_o", rdat, e.exp_dat);
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] adr;
      logic [3:0]  psel [4];
      logic [31:0] tx_dat [4];
      logic [31:0] rx_dat [5];
      flit_t       f;
      int          n;

      psel            = '{4'b0001, 4'b0110, 4'b1100, 4'b1011};
      arst_n_i        = 1'b0;
      cyc_i           = 1'b0;
      stb_i           = 1'b0;
      we_i            = 1'b0;
      adr_i           = '0;
      dat_i           = '0;
      sel_i           = '0;
      noc_out_ready_i = 1'b0;                            // Lets the transmit queue fill

      for (int i = 0; i < 4; i++) begin
         adr = 32'((i * 67 + 3) * 4);
         rng = lcg_next(rng);
         a   = rng;
         rng = lcg_next(rng);
         b   = rng;
         tbl.push_back(make_entry(1'b1, adr, a, 4'hF, 32'h0, 1'b0));
         tbl.push_back(make_entry(1'b0, adr, 32'h0, 4'hF, a, 1'b0));
         tbl.push_back(make_entry(1'b1, adr, b, psel[i], 32'h0, 1'b0));
         tbl.push_back(make_entry(1'b0, adr, 32'h0, 4'hF, ram_merge(a, b, psel[i]), 1'b0));
      end
      tbl.push_back(make_entry(1'b0, 32'h0000_0400, 32'h0, 4'hF, 32'h0, 1'b1));  // Past RAM
      tbl.push_back(make_entry(1'b1, 32'h0000_0400, a, 4'hF, 32'h0, 1'b1));
      tbl.push_back(make_entry(1'b0, 32'hF000_0000, 32'h0, 4'hF, 32'h0, 1'b1));  // Old boot ROM
      tbl.push_back(make_entry(1'b0, {NA_REGION, 24'h0, NA_TX_DATA}, 32'h0, 4'hF, 32'h0, 1'b1));
      tbl.push_back(make_entry(1'b1, {NA_REGION, 24'h0, NA_STATUS}, a, 4'hF, 32'h0, 1'b1));

      repeat (3) @(negedge clk);
      arst_n_i = 1'b1;
      @(negedge clk);
      if ({ack_o, err_o, noc_out_valid_o, irq_o, noc_in_ready_o} !== 5'b00001) begin
         report_mismatch("ack_o,err_o,noc_out_valid_o,irq_o,noc_in_ready_o",
                         32'({ack_o, err_o, noc_out_valid_o, irq_o, noc_in_ready_o}), 32'd1);
      end

      foreach (tbl[i]) run_entry(tbl[i]);

      // Transmit with the NoC output stalled
      for (int i = 0; i < 4; i++) begin
         rng       = lcg_next(rng);
         tx_dat[i] = rng;
         adr       = {NA_REGION, 24'h0, (i % 2 == 1) ? NA_TX_LAST : NA_TX_DATA};
         run_entry(make_entry(1'b1, adr, tx_dat[i], 4'hF, 32'h0, 1'b0));
      end
      run_entry(make_entry(1'b0, {NA_REGION, 24'h0, NA_STATUS}, 32'h0, 4'hF, 32'h0, 1'b0));
      run_entry(make_entry(1'b1, {NA_REGION, 24'h0, NA_TX_DATA}, b, 4'hF, 32'h0, 1'b1));
      @(negedge clk);
      noc_out_ready_i = 1'b1;
      n = 0;
      while (out_q.size() < 4 && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      @(negedge clk);
      if (out_q.size() != 4) begin
         errors++;
         $display("Expected 4 flits on the NoC output, saw %0d", out_q.size());
      end
      for (int i = 0; i < 4 && i < out_q.size(); i++) begin
         if (out_q[i].data !== tx_dat[i]) report_mismatch("noc_out_flit_o.data", out_q[i].data,
                                                          tx_dat[i]);
         if (out_q[i].last !== 1'(i % 2)) report_mismatch("noc_out_flit_o.last",
                                                          32'(out_q[i].last), 32'(i % 2));
      end

      // Receive five flits into a four-entry queue
      for (int i = 0; i < 5; i++) begin
         rng       = lcg_next(rng);
         rx_dat[i] = rng;
         f.data    = rng;
         f.last    = (i == 0) || (i == 4);
         send_q.push_back(f);
      end
      n = 0;
      while (in_acc < 4 && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      repeat (2) @(negedge clk);                         // Fifth flit has to stay out
      if (in_acc != 4) begin
         errors++;
         $display("Receive queue took %0d flits while it should hold 4", in_acc);
      end
      if (noc_in_ready_o !== 1'b0) report_mismatch("noc_in_ready_o", 32'(noc_in_ready_o), 32'd0);
      if (irq_o !== 1'b1) report_mismatch("irq_o", 32'(irq_o), 32'd1);
      // Head last flag set with 4 received and 4 transmit slots free
      run_entry(make_entry(1'b0, {NA_REGION, 24'h0, NA_STATUS}, 32'h0, 4'hF, 32'h0001_0404,
                           1'b0));
      for (int i = 0; i < 5; i++) begin
         run_entry(make_entry(1'b0, {NA_REGION, 24'h0, NA_RX_DATA}, 32'h0, 4'hF, rx_dat[i], 1'b0));
      end
      if (in_acc != 5) begin
         errors++;
         $display("Fifth flit never entered the receive queue");
      end
      if (irq_o !== 1'b0) report_mismatch("irq_o", 32'(irq_o), 32'd0);
      run_entry(make_entry(1'b0, {NA_REGION, 24'h0, NA_RX_DATA}, 32'h0, 4'hF, 32'h0, 1'b1));

      $display("%0d bus transfers, %0d errors", xfers, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
hdl/tile_pkg.sv
hdl/flit_fifo.sv
hdl/tile_ram.sv
hdl/noc_adapter.sv
hdl/bus_decoder.sv
hdl/compute_tile.sv
test/compute_tile_sva.sv
test/tb_compute_tile.sv

//--- run.sh
#!/bin/sh
# Build and run the compute tile testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      -f all.f --top-module tb_compute_tile --Mdir obj_dir -o sim_tb; then
   echo "Verilator build failed"
   exit 1
fi

if ! out=$(./obj_dir/sim_tb 2>&1); then
   echo "$out"
   echo "Simulation exited with an error status"
   exit 1
fi
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
   exit 0
fi
exit 1
